// ==== Makefile ====
# Verilator build and run for the bus fabric testbench

VERILATOR ?= verilator
TOP       ?= tb_mc_bus_fabric
BUILD_DIR ?= obj_dir
FILELIST  ?= filelist.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(wildcard src/*.sv) $(wildcard tests/*.sv)

.PHONY: all build run check clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@$(MAKE) --no-print-directory check LOG=$(LOG)

check:
	@test -f $(LOG) || (echo "no log file $(LOG), run the simulation first"; exit 1)
	@if grep -q '^TB PASSED$$' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== filelist.f ====
src/mc_bus_pkg.sv
src/dma_arbiter.sv
src/io_page_decoder.sv
src/sd_card_dispatcher.sv
src/mc_bus_fabric.sv
tests/tb_mc_bus_fabric.sv

// ==== src/dma_arbiter.sv ====
`timescale 1ns/1ps
// bus-master arbiter for the cpu and the rk/my dma controllers
// master-to-bus multiplexer and ack return path
module dma_arbiter (
   input  logic                          wb_clk,
   input  logic                          rst_n_i,
   input  logic                          init_i,      // bus init, sync clear
   // cpu master
   input  mc_bus_pkg::bus_addr_t         cpu_adr_i,
   input  mc_bus_pkg::bus_data_t         cpu_dat_i,
   input  logic                          cpu_cyc_i,
   input  logic                          cpu_we_i,
   input  mc_bus_pkg::bus_sel_t          cpu_sel_i,
   input  logic                          cpu_stb_i,
   output logic                          cpu_gnt_o,   // 0 = cpu parked
   output logic                          cpu_ack_o,
   // rk dma master
   input  logic                          rk_req_i,    // doubles as rk cyc
   input  logic [mc_bus_pkg::ADDR_W-2:0] rk_adr_i,    // 16-bit dma address
   input  mc_bus_pkg::bus_data_t         rk_dat_i,
   input  logic                          rk_stb_i,
   input  logic                          rk_we_i,
   output logic                          rk_gnt_o,
   output logic                          rk_ack_o,
   // my dma master
   input  logic                          my_req_i,    // doubles as my cyc
   input  logic [mc_bus_pkg::ADDR_W-2:0] my_adr_i,
   input  mc_bus_pkg::bus_data_t         my_dat_i,
   input  logic                          my_stb_i,
   input  logic                          my_we_i,
   output logic                          my_gnt_o,
   output logic                          my_ack_o,
   // shared bus
   input  logic                          bus_ack_i,   // or of all slave acks
   output mc_bus_pkg::bus_addr_t         bus_adr_o,
   output mc_bus_pkg::bus_data_t         bus_dat_o,
   output logic                          bus_cyc_o,
   output logic                          bus_we_o,
   output mc_bus_pkg::bus_sel_t          bus_sel_o,
   output logic                          bus_stb_o
);

   logic rk_gnt;    // rk owns the bus
   logic my_gnt;    // my owns the bus
   logic dma_gnt;   // any dma owner

   //******************************
   //* grant flops
   //******************************
   always_ff @(posedge wb_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rk_gnt <= 1'b0;
         my_gnt <= 1'b0;
      end else if (init_i) begin
         rk_gnt <= 1'b0;
         my_gnt <= 1'b0;
      end else if (!bus_cyc_o) begin       // owner changes only between cycles
         rk_gnt <= rk_req_i;               // rk first
         my_gnt <= my_req_i & ~rk_req_i;
      end
   end

   assign dma_gnt   = rk_gnt | my_gnt;
   assign cpu_gnt_o = ~dma_gnt;            // no dma request -> cpu
   assign rk_gnt_o  = rk_gnt;
   assign my_gnt_o  = my_gnt;

   //******************************
   //* master mux
   //******************************
   always_comb begin
      if (rk_gnt) begin
         bus_adr_o = {1'b0, rk_adr_i};    // dma sees user space only
         bus_dat_o = rk_dat_i;
         bus_cyc_o = rk_req_i;
         bus_we_o  = rk_we_i;
         bus_sel_o = '1;                  // whole words
         bus_stb_o = rk_stb_i;
      end else if (my_gnt) begin
         bus_adr_o = {1'b0, my_adr_i};
         bus_dat_o = my_dat_i;
         bus_cyc_o = my_req_i;
         bus_we_o  = my_we_i;
         bus_sel_o = '1;
         bus_stb_o = my_stb_i;
      end else begin
         bus_adr_o = cpu_adr_i;
         bus_dat_o = cpu_dat_i;
         bus_cyc_o = cpu_cyc_i;
         bus_we_o  = cpu_we_i;
         bus_sel_o = cpu_sel_i;
         bus_stb_o = cpu_stb_i;
      end
   end

   // ack back to the owner only
   assign cpu_ack_o = bus_ack_i & ~dma_gnt;
   assign rk_ack_o  = bus_ack_i & rk_gnt;
   assign my_ack_o  = bus_ack_i & my_gnt;

   // rk and my never share the bus
   a_dma_gnt_excl: assert property (@(posedge wb_clk) disable iff (!rst_n_i)
      !(rk_gnt && my_gnt));

   // owner held through the bus cycle unless init
   a_gnt_stable: assert property (@(posedge wb_clk) disable iff (!rst_n_i)
      (bus_cyc_o && !init_i) |=> $stable({rk_gnt, my_gnt}));

endmodule

// ==== src/io_page_decoder.sv ====
`timescale 1ns/1ps
// address decoder for the io page, monitor rom and dram
// ack or and read-data multiplexer
module io_page_decoder (
   input  mc_bus_pkg::bus_addr_t bus_adr_i,
   input  logic                  bus_cyc_i,
   input  logic                  bus_stb_i,
   input  mc_bus_pkg::dev_vec_t  dev_ack_i,    // per-slave acks
   input  mc_bus_pkg::dev_data_t dev_dat_i,    // per-slave read data
   output mc_bus_pkg::dev_vec_t  dev_stb_o,    // per-slave strobes
   output logic                  bus_ack_o,
   output mc_bus_pkg::bus_data_t bus_rdat_o
);

   mc_bus_pkg::dev_vec_t hit;      // address match, before cyc/stb
   logic                 access;   // live bus access

   // register block match on the bits above the span
   function automatic logic io_hit(input mc_bus_pkg::bus_addr_t adr,
                                   input mc_bus_pkg::bus_addr_t base,
                                   input int unsigned span_w);
      return (adr >> span_w) == (base >> span_w);
   endfunction

   //******************************
   //* slave selects
   //******************************
   always_comb begin
      hit = '0;
      // io page registers
      hit[mc_bus_pkg::DEV_UART1] = io_hit(bus_adr_i, mc_bus_pkg::UART1_BASE,
                                          mc_bus_pkg::UART_SPAN_W);   // 177560-177566
      hit[mc_bus_pkg::DEV_UART2] = io_hit(bus_adr_i, mc_bus_pkg::UART2_BASE,
                                          mc_bus_pkg::UART_SPAN_W);   // 176500-176506
      hit[mc_bus_pkg::DEV_LPT]   = io_hit(bus_adr_i, mc_bus_pkg::LPT_BASE,
                                          mc_bus_pkg::LPT_SPAN_W);    // 177514-177516
      hit[mc_bus_pkg::DEV_RK]    = io_hit(bus_adr_i, mc_bus_pkg::RK_BASE,
                                          mc_bus_pkg::RK_SPAN_W);     // 177400-177416
      hit[mc_bus_pkg::DEV_DW]    = io_hit(bus_adr_i, mc_bus_pkg::DW_BASE,
                                          mc_bus_pkg::DW_SPAN_W);     // 174000-174036
      hit[mc_bus_pkg::DEV_RX]    = io_hit(bus_adr_i, mc_bus_pkg::RX_BASE,
                                          mc_bus_pkg::RX_SPAN_W);     // 177170-177172
      hit[mc_bus_pkg::DEV_MY]    = io_hit(bus_adr_i, mc_bus_pkg::MY_BASE,
                                          mc_bus_pkg::MY_SPAN_W);     // 172140-172142
      hit[mc_bus_pkg::DEV_KGD]   = io_hit(bus_adr_i, mc_bus_pkg::KGD_BASE,
                                          mc_bus_pkg::KGD_SPAN_W);    // 176640-176646
      // monitor rom, console space only
      hit[mc_bus_pkg::DEV_ROM]   = (bus_adr_i[16:13] == mc_bus_pkg::ROM_PAGE);
      // user mode sees dram below 160000
      // console mode sees only the top 8k as dram
      hit[mc_bus_pkg::DEV_DRAM]  = (bus_adr_i[15:13] != 3'b111) ^ bus_adr_i[16];
   end

   assign access    = bus_cyc_i & bus_stb_i;
   assign dev_stb_o = hit & {mc_bus_pkg::N_DEV{access}};   // no strobe outside a cycle

   //******************************
   //* ack and read data
   //******************************
   assign bus_ack_o = |dev_ack_i;   // every slave may end the cycle

   always_comb begin
      bus_rdat_o = '0;   // unmapped reads return 0
      for (int i = 0; i < mc_bus_pkg::N_DEV; i++) begin
         if (dev_stb_o[i]) begin
            bus_rdat_o = bus_rdat_o | dev_dat_i[i];
         end
      end
   end

endmodule

// ==== src/mc_bus_fabric.sv ====
`timescale 1ns/1ps
// mc1201.02 system bus fabric
// dma arbiter, io page decoder and sd card dispatcher
module mc_bus_fabric (
   input  logic                              wb_clk,
   input  logic                              rst_n_i,
   input  logic                              init_i,       // bus init from cpu side
   // cpu master
   input  mc_bus_pkg::bus_addr_t             cpu_adr_i,
   input  mc_bus_pkg::bus_data_t             cpu_dat_i,
   input  logic                              cpu_cyc_i,
   input  logic                              cpu_we_i,
   input  mc_bus_pkg::bus_sel_t              cpu_sel_i,
   input  logic                              cpu_stb_i,
   output logic                              cpu_gnt_o,
   output logic                              cpu_ack_o,
   // rk dma master
   input  logic                              rk_req_i,
   input  logic [mc_bus_pkg::ADDR_W-2:0]     rk_adr_i,
   input  mc_bus_pkg::bus_data_t             rk_dat_i,
   input  logic                              rk_stb_i,
   input  logic                              rk_we_i,
   output logic                              rk_gnt_o,
   output logic                              rk_ack_o,
   // my dma master
   input  logic                              my_req_i,
   input  logic [mc_bus_pkg::ADDR_W-2:0]     my_adr_i,
   input  mc_bus_pkg::bus_data_t             my_dat_i,
   input  logic                              my_stb_i,
   input  logic                              my_we_i,
   output logic                              my_gnt_o,
   output logic                              my_ack_o,
   // slave side
   output mc_bus_pkg::bus_addr_t             bus_adr_o,
   output mc_bus_pkg::bus_data_t             bus_dat_o,    // write data
   output logic                              bus_we_o,
   output mc_bus_pkg::bus_sel_t              bus_sel_o,
   output mc_bus_pkg::dev_vec_t              dev_stb_o,
   input  mc_bus_pkg::dev_vec_t              dev_ack_i,
   input  mc_bus_pkg::dev_data_t             dev_dat_i,
   output mc_bus_pkg::bus_data_t             bus_rdat_o,   // read data to all masters
   // sd card clients rk, dw, dx, my
   input  logic [mc_bus_pkg::N_SD-1:0]       sd_req_i,
   input  logic [mc_bus_pkg::N_SD-1:0]       sd_mosi_i,
   input  logic [mc_bus_pkg::N_SD-1:0]       sd_cs_i,
   output logic [mc_bus_pkg::N_SD-1:0]       sd_ack_o,
   output logic                              sdcard_mosi_o,
   output logic                              sdcard_cs_o
);

   logic bus_cyc;   // muxed cycle
   logic bus_stb;   // muxed strobe
   logic bus_ack;   // or of slave acks

   //******************************
   //* bus masters
   //******************************
   dma_arbiter u_arbiter (
      .wb_clk    (wb_clk),    .rst_n_i   (rst_n_i),   .init_i    (init_i),
      .cpu_adr_i (cpu_adr_i), .cpu_dat_i (cpu_dat_i), .cpu_cyc_i (cpu_cyc_i),
      .cpu_we_i  (cpu_we_i),  .cpu_sel_i (cpu_sel_i), .cpu_stb_i (cpu_stb_i),
      .cpu_gnt_o (cpu_gnt_o), .cpu_ack_o (cpu_ack_o),
      .rk_req_i  (rk_req_i),  .rk_adr_i  (rk_adr_i),  .rk_dat_i  (rk_dat_i),
      .rk_stb_i  (rk_stb_i),  .rk_we_i   (rk_we_i),
      .rk_gnt_o  (rk_gnt_o),  .rk_ack_o  (rk_ack_o),
      .my_req_i  (my_req_i),  .my_adr_i  (my_adr_i),  .my_dat_i  (my_dat_i),
      .my_stb_i  (my_stb_i),  .my_we_i   (my_we_i),
      .my_gnt_o  (my_gnt_o),  .my_ack_o  (my_ack_o),
      .bus_ack_i (bus_ack),   .bus_adr_o (bus_adr_o), .bus_dat_o (bus_dat_o),
      .bus_cyc_o (bus_cyc),   .bus_we_o  (bus_we_o),  .bus_sel_o (bus_sel_o),
      .bus_stb_o (bus_stb)
   );

   //******************************
   //* slave decode
   //******************************
   io_page_decoder u_decoder (
      .bus_adr_i  (bus_adr_o),
      .bus_cyc_i  (bus_cyc),
      .bus_stb_i  (bus_stb),
      .dev_ack_i  (dev_ack_i),
      .dev_dat_i  (dev_dat_i),
      .dev_stb_o  (dev_stb_o),
      .bus_ack_o  (bus_ack),
      .bus_rdat_o (bus_rdat_o)
   );

   // sd card shared by the disk controllers
   sd_card_dispatcher #(
      .N_CLIENTS (mc_bus_pkg::N_SD)
   ) u_sd_disp (
      .wb_clk        (wb_clk),
      .rst_n_i       (rst_n_i),
      .init_i        (init_i),
      .sd_req_i      (sd_req_i),
      .sd_mosi_i     (sd_mosi_i),
      .sd_cs_i       (sd_cs_i),
      .sd_ack_o      (sd_ack_o),
      .sdcard_mosi_o (sdcard_mosi_o),
      .sdcard_cs_o   (sdcard_cs_o)
   );

   // address map has no overlaps, whoever masters the bus
   a_dev_stb_onehot: assert property (@(posedge wb_clk) disable iff (!rst_n_i)
      $onehot0(dev_stb_o));

endmodule

// ==== src/mc_bus_pkg.sv ====
// system bus widths and vector types
// slave index list for the io page decoder
// octal io page base addresses and span widths
package mc_bus_pkg;

   //******************************
   //* bus widths
   //******************************
   localparam int ADDR_W = 17;   // bit 16 set = console (halt) space
   localparam int DATA_W = 16;
   localparam int SEL_W  = 2;    // byte lanes

   typedef logic [ADDR_W-1:0] bus_addr_t;
   typedef logic [DATA_W-1:0] bus_data_t;
   typedef logic [SEL_W-1:0]  bus_sel_t;

   //******************************
   //* bus slaves
   //******************************
   localparam int N_DEV = 10;

   typedef enum int unsigned {
      DEV_ROM, DEV_DRAM, DEV_UART1, DEV_UART2, DEV_LPT,
      DEV_RK, DEV_DW, DEV_RX, DEV_MY, DEV_KGD
   } dev_idx_e;

   typedef logic [N_DEV-1:0]             dev_vec_t;    // one bit per slave
   typedef logic [N_DEV-1:0][DATA_W-1:0] dev_data_t;   // read data per slave

   localparam int N_SD = 4;   // sd clients rk, dw, dx, my

   // io page bases, bit 16 clear
   localparam bus_addr_t UART1_BASE = 17'o177560;   // console tt
   localparam bus_addr_t UART2_BASE = 17'o176500;   // second serial port
   localparam bus_addr_t LPT_BASE   = 17'o177514;   // printer
   localparam bus_addr_t RK_BASE    = 17'o177400;   // rk11 disk
   localparam bus_addr_t DW_BASE    = 17'o174000;   // dw hard disk
   localparam bus_addr_t RX_BASE    = 17'o177170;   // rx01 floppy
   localparam bus_addr_t MY_BASE    = 17'o172140;   // my floppy
   localparam bus_addr_t KGD_BASE   = 17'o176640;   // graphics

   localparam int UART_SPAN_W = 3;   // 4 words
   localparam int LPT_SPAN_W  = 2;
   localparam int RK_SPAN_W   = 4;   // 8 registers
   localparam int DW_SPAN_W   = 5;
   localparam int RX_SPAN_W   = 2;
   localparam int MY_SPAN_W   = 2;
   localparam int KGD_SPAN_W  = 3;

   localparam logic [3:0] ROM_PAGE = 4'b1110;   // monitor rom at 140000 in console space

endpackage

// ==== src/sd_card_dispatcher.sv ====
`timescale 1ns/1ps
// sd card sharing between disk controllers
// request/grant dispatcher and mosi/cs multiplexer
module sd_card_dispatcher #(
   parameter int N_CLIENTS = 4   // client 0 owns the lines when idle
) (
   input  logic                 wb_clk,
   input  logic                 rst_n_i,
   input  logic                 init_i,      // bus init, sync clear
   input  logic [N_CLIENTS-1:0] sd_req_i,    // request levels
   input  logic [N_CLIENTS-1:0] sd_mosi_i,
   input  logic [N_CLIENTS-1:0] sd_cs_i,
   output logic [N_CLIENTS-1:0] sd_ack_o,    // one-hot grant
   output logic                 sdcard_mosi_o,
   output logic                 sdcard_cs_o
);

   logic [N_CLIENTS-1:0] ack_q;       // current grant
   logic [N_CLIENTS-1:0] first_req;   // lowest requester, one-hot
   logic                 idle;        // card free

   assign idle      = ~|ack_q;
   assign first_req = sd_req_i & (~sd_req_i + 1'b1);   // isolate lowest set bit

   //******************************
   //* grant fsm
   //******************************
   // idle -> grant lowest requester next clock
   // busy -> hold until the owner drops its request
   always_ff @(posedge wb_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_q <= '0;
      end else if (init_i) begin
         ack_q <= '0;
      end else if (idle) begin
         ack_q <= first_req;
      end else begin
         ack_q <= ack_q & sd_req_i;   // release goes back to idle
      end
   end

   assign sd_ack_o = ack_q;

   //******************************
   //* card line mux
   //******************************
   always_comb begin
      sdcard_mosi_o = sd_mosi_i[0];   // default owner
      sdcard_cs_o   = sd_cs_i[0];
      for (int i = 1; i < N_CLIENTS; i++) begin
         if (ack_q[i]) begin
            sdcard_mosi_o = sd_mosi_i[i];
            sdcard_cs_o   = sd_cs_i[i];
         end
      end
   end

   // at most one controller on the card
   a_sd_ack_onehot: assert property (@(posedge wb_clk) disable iff (!rst_n_i)
      $onehot0(sd_ack_o));

endmodule

// ==== tests/tb_mc_bus_fabric.sv ====
`timescale 1ns/1ps
// testbench for the mc1201.02 bus fabric
// decode table with random slave data, ack or, dma arbitration
// sd card dispatch and bus init, watchdog and error summary
module tb_mc_bus_fabric;

   localparam int CLK_PERIOD = 100;
   localparam int N_CASES    = 20;
   localparam int NO_DEV     = -1;   // unmapped address

   logic                          wb_clk;
   logic                          rst_n_i;
   logic                          init_i;
   mc_bus_pkg::bus_addr_t         cpu_adr_i;
   mc_bus_pkg::bus_data_t         cpu_dat_i;
   logic                          cpu_cyc_i;
   logic                          cpu_we_i;
   mc_bus_pkg::bus_sel_t          cpu_sel_i;
   logic                          cpu_stb_i;
   logic                          cpu_gnt_o;
   logic                          cpu_ack_o;
   logic                          rk_req_i;
   logic [mc_bus_pkg::ADDR_W-2:0] rk_adr_i;
   mc_bus_pkg::bus_data_t         rk_dat_i;
   logic                          rk_stb_i;
   logic                          rk_we_i;
   logic                          rk_gnt_o;
   logic                          rk_ack_o;
   logic                          my_req_i;
   logic [mc_bus_pkg::ADDR_W-2:0] my_adr_i;
   mc_bus_pkg::bus_data_t         my_dat_i;
   logic                          my_stb_i;
   logic                          my_we_i;
   logic                          my_gnt_o;
   logic                          my_ack_o;
   mc_bus_pkg::bus_addr_t         bus_adr_o;
   mc_bus_pkg::bus_data_t         bus_dat_o;
   logic                          bus_we_o;
   mc_bus_pkg::bus_sel_t          bus_sel_o;
   mc_bus_pkg::dev_vec_t          dev_stb_o;
   mc_bus_pkg::dev_vec_t          dev_ack_i;
   mc_bus_pkg::dev_data_t         dev_dat_i;
   mc_bus_pkg::bus_data_t         bus_rdat_o;
   logic [mc_bus_pkg::N_SD-1:0]   sd_req_i;
   logic [mc_bus_pkg::N_SD-1:0]   sd_mosi_i;
   logic [mc_bus_pkg::N_SD-1:0]   sd_cs_i;
   logic [mc_bus_pkg::N_SD-1:0]   sd_ack_o;
   logic                          sdcard_mosi_o;
   logic                          sdcard_cs_o;

   mc_bus_pkg::bus_addr_t case_adr [N_CASES];   // decode table, address
   int                    case_dev [N_CASES];   // expected slave or NO_DEV
   int                    n_loaded;
   int                    err_cnt;
   int                    chk_cnt;
   logic [31:0]           rng;

   mc_bus_fabric UUT (.*);

   //******************************
   //* clock and watchdog
   //******************************
   initial begin
      wb_clk = 1'b0;
      forever #(CLK_PERIOD / 2) wb_clk = ~wb_clk;
   end

   initial begin
      #(CLK_PERIOD * (N_CASES * 20 + 200));   // table plus fixed scenarios
      $display("timeout: the test sequence did not finish in time");
      $display("TB FAILED");
      $finish;
   end

   //******************************
   //* helpers
   //******************************
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic mc_bus_pkg::dev_vec_t dev_onehot(input int dev);
      if (dev == NO_DEV) return '0;
      return mc_bus_pkg::dev_vec_t'(1) << dev;
   endfunction

   // selected slave's word, zero when nothing answers
   function automatic mc_bus_pkg::bus_data_t expected_rdat(input int dev);
      if (dev == NO_DEV) return '0;
      return dev_dat_i[dev];
   endfunction

   task automatic next_drive_slot();
      @(posedge wb_clk);
      #5;
   endtask

   task automatic sample_point();
      @(negedge wb_clk);   // mid cycle, all outputs settled
   endtask

   task automatic randomize_dev_data();
      for (int i = 0; i < mc_bus_pkg::N_DEV; i++) begin
         rng = xorshift32(rng);
         dev_dat_i[i] = rng[15:0];
      end
   endtask

   task automatic add_case(input mc_bus_pkg::bus_addr_t adr, input int dev);
      case_adr[n_loaded] = adr;
      case_dev[n_loaded] = dev;
      n_loaded++;
   endtask

   //******************************
   //* compare tasks
   //******************************
   task automatic check_bit(input string name, input logic act, input logic exp);
      chk_cnt++;
      if (act !== exp) begin
         err_cnt++;
         $display("error: %s = %h, expected %h at %0t", name, act, exp, $time);
      end
   endtask

   task automatic check_dev_vec(input string name, input mc_bus_pkg::dev_vec_t act,
                                input mc_bus_pkg::dev_vec_t exp);
      chk_cnt++;
      if (act !== exp) begin
         err_cnt++;
         $display("error: %s = %h, expected %h at %0t", name, act, exp, $time);
      end
   endtask

   task automatic check_data(input string name, input mc_bus_pkg::bus_data_t act,
                             input mc_bus_pkg::bus_data_t exp);
      chk_cnt++;
      if (act !== exp) begin
         err_cnt++;
         $display("error: %s = %h, expected %h at %0t", name, act, exp, $time);
      end
   endtask

   task automatic check_addr(input string name, input mc_bus_pkg::bus_addr_t act,
                             input mc_bus_pkg::bus_addr_t exp);
      chk_cnt++;
      if (act !== exp) begin
         err_cnt++;
         $display("error: %s = %h, expected %h at %0t", name, act, exp, $time);
      end
   endtask

   task automatic check_sel(input string name, input mc_bus_pkg::bus_sel_t act,
                            input mc_bus_pkg::bus_sel_t exp);
      chk_cnt++;
      if (act !== exp) begin
         err_cnt++;
         $display("error: %s = %h, expected %h at %0t", name, act, exp, $time);
      end
   endtask

   task automatic check_sd_vec(input string name, input logic [mc_bus_pkg::N_SD-1:0] act,
                               input logic [mc_bus_pkg::N_SD-1:0] exp);
      chk_cnt++;
      if (act !== exp) begin
         err_cnt++;
         $display("error: %s = %h, expected %h at %0t", name, act, exp, $time);
      end
   endtask

   // card lines must follow the given client
   task automatic check_card_lines(input int owner);
      check_bit("sdcard_mosi_o", sdcard_mosi_o, sd_mosi_i[owner]);
      check_bit("sdcard_cs_o", sdcard_cs_o, sd_cs_i[owner]);
   endtask

   //******************************
   //* decode table
   //******************************
   task automatic load_table();
      n_loaded = 0;
      add_case(17'o177560, mc_bus_pkg::DEV_UART1);
      add_case(17'o177566, mc_bus_pkg::DEV_UART1);   // top of span
      add_case(17'o176500, mc_bus_pkg::DEV_UART2);
      add_case(17'o176506, mc_bus_pkg::DEV_UART2);
      add_case(17'o177514, mc_bus_pkg::DEV_LPT);
      add_case(17'o177400, mc_bus_pkg::DEV_RK);
      add_case(17'o177416, mc_bus_pkg::DEV_RK);
      add_case(17'o174000, mc_bus_pkg::DEV_DW);
      add_case(17'o174036, mc_bus_pkg::DEV_DW);
      add_case(17'o177170, mc_bus_pkg::DEV_RX);
      add_case(17'o172140, mc_bus_pkg::DEV_MY);
      add_case(17'o176640, mc_bus_pkg::DEV_KGD);
      add_case(17'o340000, mc_bus_pkg::DEV_ROM);     // console 140000
      add_case(17'o357776, mc_bus_pkg::DEV_ROM);
      add_case(17'o000000, mc_bus_pkg::DEV_DRAM);    // user space
      add_case(17'o157776, mc_bus_pkg::DEV_DRAM);
      add_case(17'o360000, mc_bus_pkg::DEV_DRAM);    // console top 8k
      add_case(17'o377776, mc_bus_pkg::DEV_DRAM);
      add_case(17'o177000, NO_DEV);                  // hole in the io page
      add_case(17'o200000, NO_DEV);                  // console, below rom
      if (n_loaded != N_CASES) begin
         err_cnt++;
         $display("decode table holds %0d cases instead of %0d", n_loaded, N_CASES);
      end
   endtask

   //******************************
   //* test scenarios
   //******************************
   task automatic test_reset_state();
      next_drive_slot();
      cpu_stb_i = 1'b1;   // strobe alone, no cycle
      sample_point();
      check_bit("cpu_gnt_o", cpu_gnt_o, 1'b1);
      check_bit("rk_gnt_o", rk_gnt_o, 1'b0);
      check_bit("my_gnt_o", my_gnt_o, 1'b0);
      check_sd_vec("sd_ack_o", sd_ack_o, '0);
      check_dev_vec("dev_stb_o", dev_stb_o, '0);
      next_drive_slot();
      cpu_stb_i = 1'b0;
   endtask

   task automatic test_decode_table();
      mc_bus_pkg::dev_vec_t exp_stb;
      for (int i = 0; i < N_CASES; i++) begin
         exp_stb = dev_onehot(case_dev[i]);
         next_drive_slot();
         randomize_dev_data();
         cpu_adr_i = case_adr[i];
         cpu_cyc_i = 1'b0;
         cpu_stb_i = 1'b1;
         dev_ack_i = '0;
         sample_point();
         check_dev_vec("dev_stb_o", dev_stb_o, '0);   // no cyc, no strobe
         next_drive_slot();
         cpu_cyc_i = 1'b1;
         dev_ack_i = exp_stb;                          // slave answers at once
         sample_point();
         check_addr("bus_adr_o", bus_adr_o, case_adr[i]);
         check_dev_vec("dev_stb_o", dev_stb_o, exp_stb);
         check_data("bus_rdat_o", bus_rdat_o, expected_rdat(case_dev[i]));
         check_bit("cpu_ack_o", cpu_ack_o, case_dev[i] != NO_DEV);
      end
      next_drive_slot();
      cpu_cyc_i = 1'b0;
      cpu_stb_i = 1'b0;
      dev_ack_i = '0;
   endtask

   // an ack from a slave that is not selected still ends the cycle
   task automatic test_ack_or();
      next_drive_slot();
      cpu_adr_i = 17'o177000;
      cpu_cyc_i = 1'b1;
      cpu_stb_i = 1'b1;
      dev_ack_i = dev_onehot(mc_bus_pkg::DEV_LPT);
      sample_point();
      check_dev_vec("dev_stb_o", dev_stb_o, '0);
      check_data("bus_rdat_o", bus_rdat_o, '0);
      check_bit("cpu_ack_o", cpu_ack_o, 1'b1);
      next_drive_slot();
      cpu_cyc_i = 1'b0;
      cpu_stb_i = 1'b0;
      dev_ack_i = '0;
   endtask

   task automatic test_dma_arbitration();
      // both dma masters request on an idle bus
      next_drive_slot();
      cpu_sel_i = 2'b01;
      rk_req_i  = 1'b1;
      rk_stb_i  = 1'b1;
      rk_we_i   = 1'b1;
      rk_adr_i  = 16'o123456;
      rk_dat_i  = 16'h5a3c;
      my_req_i  = 1'b1;
      my_stb_i  = 1'b1;
      my_adr_i  = 16'o054320;
      sample_point();
      check_bit("rk_gnt_o", rk_gnt_o, 1'b0);   // grant is registered
      check_bit("cpu_gnt_o", cpu_gnt_o, 1'b1);
      next_drive_slot();
      dev_ack_i = dev_onehot(mc_bus_pkg::DEV_DRAM);
      sample_point();
      check_bit("rk_gnt_o", rk_gnt_o, 1'b1);
      check_bit("my_gnt_o", my_gnt_o, 1'b0);
      check_bit("cpu_gnt_o", cpu_gnt_o, 1'b0);
      check_addr("bus_adr_o", bus_adr_o, 17'o123456);   // zero-extended
      check_sel("bus_sel_o", bus_sel_o, 2'b11);
      check_data("bus_dat_o", bus_dat_o, 16'h5a3c);
      check_bit("bus_we_o", bus_we_o, 1'b1);
      check_dev_vec("dev_stb_o", dev_stb_o, dev_onehot(mc_bus_pkg::DEV_DRAM));
      check_bit("rk_ack_o", rk_ack_o, 1'b1);
      check_bit("my_ack_o", my_ack_o, 1'b0);
      check_bit("cpu_ack_o", cpu_ack_o, 1'b0);
      next_drive_slot();
      sample_point();
      check_bit("my_gnt_o", my_gnt_o, 1'b0);    // rk still holds the bus
      // rk releases, my takes over
      next_drive_slot();
      rk_req_i  = 1'b0;
      rk_stb_i  = 1'b0;
      next_drive_slot();
      sample_point();
      check_bit("rk_gnt_o", rk_gnt_o, 1'b0);
      check_bit("my_gnt_o", my_gnt_o, 1'b1);
      check_addr("bus_adr_o", bus_adr_o, 17'o054320);
      check_bit("my_ack_o", my_ack_o, 1'b1);
      check_bit("rk_ack_o", rk_ack_o, 1'b0);
      next_drive_slot();
      my_req_i  = 1'b0;
      my_stb_i  = 1'b0;
      dev_ack_i = '0;
      next_drive_slot();
      sample_point();
      check_bit("my_gnt_o", my_gnt_o, 1'b0);
      check_bit("cpu_gnt_o", cpu_gnt_o, 1'b1);
      // request during a cpu cycle waits for cyc to fall
      next_drive_slot();
      cpu_adr_i = 17'o001000;
      cpu_cyc_i = 1'b1;
      cpu_stb_i = 1'b1;
      next_drive_slot();
      rk_req_i  = 1'b1;
      next_drive_slot();
      sample_point();
      check_bit("rk_gnt_o", rk_gnt_o, 1'b0);
      next_drive_slot();
      cpu_cyc_i = 1'b0;
      cpu_stb_i = 1'b0;
      sample_point();
      check_bit("rk_gnt_o", rk_gnt_o, 1'b0);
      next_drive_slot();
      sample_point();
      check_bit("rk_gnt_o", rk_gnt_o, 1'b1);
      check_bit("cpu_gnt_o", cpu_gnt_o, 1'b0);
      next_drive_slot();
      rk_req_i  = 1'b0;
   endtask

   task automatic test_sd_dispatch();
      next_drive_slot();
      sd_mosi_i = 4'b0101;   // rk and dw differ on both lines
      sd_cs_i   = 4'b1010;
      sd_req_i  = 4'b1010;   // dw and my
      sample_point();
      check_sd_vec("sd_ack_o", sd_ack_o, '0);
      check_card_lines(0);
      next_drive_slot();
      sample_point();
      check_sd_vec("sd_ack_o", sd_ack_o, 4'b0010);
      check_card_lines(1);
      // rk asks while dw owns the card
      next_drive_slot();
      sd_mosi_i = 4'b0110;   // dw mosi toggles, rk still differs
      sd_req_i  = 4'b1011;
      sample_point();
      check_card_lines(1);
      next_drive_slot();
      sample_point();
      check_sd_vec("sd_ack_o", sd_ack_o, 4'b0010);   // no preemption
      // dw lets go, one idle clock, then rk
      next_drive_slot();
      sd_req_i  = 4'b1001;
      next_drive_slot();
      sample_point();
      check_sd_vec("sd_ack_o", sd_ack_o, '0);
      check_card_lines(0);
      next_drive_slot();
      sample_point();
      check_sd_vec("sd_ack_o", sd_ack_o, 4'b0001);
      check_card_lines(0);
      next_drive_slot();
      sd_req_i  = '0;
      next_drive_slot();
      sample_point();
      check_sd_vec("sd_ack_o", sd_ack_o, '0);
   endtask

   task automatic test_bus_init();
      next_drive_slot();
      rk_req_i = 1'b1;
      sd_req_i = 4'b0100;   // dx
      next_drive_slot();
      sample_point();
      check_bit("rk_gnt_o", rk_gnt_o, 1'b1);
      check_sd_vec("sd_ack_o", sd_ack_o, 4'b0100);
      next_drive_slot();
      init_i   = 1'b1;
      next_drive_slot();
      init_i   = 1'b0;
      rk_req_i = 1'b0;
      sd_req_i = '0;
      sample_point();
      check_bit("rk_gnt_o", rk_gnt_o, 1'b0);
      check_bit("my_gnt_o", my_gnt_o, 1'b0);
      check_bit("cpu_gnt_o", cpu_gnt_o, 1'b1);
      check_sd_vec("sd_ack_o", sd_ack_o, '0);
   endtask

   //******************************
   //* main sequence
   //******************************
   initial begin
      rst_n_i   = 1'b0;
      init_i    = 1'b0;
      cpu_adr_i = '0;
      cpu_dat_i = '0;
      cpu_cyc_i = 1'b0;
      cpu_we_i  = 1'b0;
      cpu_sel_i = 2'b11;
      cpu_stb_i = 1'b0;
      rk_req_i  = 1'b0;
      rk_adr_i  = '0;
      rk_dat_i  = '0;
      rk_stb_i  = 1'b0;
      rk_we_i   = 1'b0;
      my_req_i  = 1'b0;
      my_adr_i  = '0;
      my_dat_i  = '0;
      my_stb_i  = 1'b0;
      my_we_i   = 1'b0;
      dev_ack_i = '0;
      dev_dat_i = '0;
      sd_req_i  = '0;
      sd_mosi_i = '0;
      sd_cs_i   = '0;
      err_cnt   = 0;
      chk_cnt   = 0;
      rng       = 32'h7ae3;
      load_table();
      repeat (10) @(posedge wb_clk);
      #5;
      rst_n_i = 1'b1;
      test_reset_state();
      test_decode_table();
      test_ack_or();
      test_dma_arbitration();
      test_sd_dispatch();
      test_bus_init();
      next_drive_slot();
      $display("tb summary: %0d checks, %0d errors", chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule
